/* verilog.f */
verilog/mic_pkg.sv
verilog/mic_cond.sv
verilog/mic_loop.sv
verilog/mic_stack.sv
verilog/mic_seq.sv
verilog/mic_top.sv
sim/mic_props.sv
sim/mic_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module mic_tb -f verilog.f -o mic_sim \
  > build.log 2>&1 \
  && ./obj_dir/mic_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "^TB PASSED$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* sim/mic_tb.sv */
/*
  Sequencer testbench
  Models the control store as a table looked up by ma and runs
  directed tests for sequencing, call and return, conditional
  branches, counted loops and a random branch chain
*/
`timescale 1ns/1ps

module mic_tb;

  localparam int STACK_DEPTH = 4;
  localparam int TIMEOUT     = 50; // Cycles allowed per wait

  logic            mclk;
  logic            rst_n;
  mic_pkg::micro_s micro;
  mic_pkg::flags_s flags;
  logic            ld_lc;
  mic_pkg::lc_t    lc_val;
  mic_pkg::addr_t  ma;
  logic            cond;
  logic            lcz;
  logic            deep;

  mic_pkg::micro_s cstore [4096]; // Control store image
  int              errors;
  int              timeouts;
  int              seed;

  always #10 mclk = ~mclk;

  // Store answers the current address within the same cycle
  assign micro = rst_n ? cstore[ma] : mic_pkg::micro_s'(0);

  mic_top #(
    .STACK_DEPTH(STACK_DEPTH)
  ) dut_i (
    .mclk   (mclk),
    .rst_n  (rst_n),
    .micro  (micro),
    .flags  (flags),
    .ld_lc  (ld_lc),
    .lc_val (lc_val),
    .ma     (ma),
    .cond   (cond),
    .lcz    (lcz),
    .deep   (deep)
  );

  bind mic_seq mic_props #(
    .STACK_DEPTH(STACK_DEPTH)
  ) props_i (
    .mclk  (mclk),
    .rst_n (rst_n),
    .micro (micro),
    .ma    (ma),
    .push  (push),
    .pop   (pop)
  );

  function automatic mic_pkg::micro_s jump_word(mic_pkg::mic_op_e op, mic_pkg::addr_t target);
    mic_pkg::micro_s w;
    w.op = op;
    w.field.jump.target = target;
    return w;
  endfunction

  function automatic mic_pkg::micro_s cond_word(logic [2:0] tsel, logic sense, logic [7:0] off);
    mic_pkg::micro_s w;
    w.op = mic_pkg::OP_CJMP;
    w.field.cond.tsel     = tsel;
    w.field.cond.sense    = sense;
    w.field.cond.page_off = off;
    return w;
  endfunction

  // Selected flag must match the sense bit
  function automatic logic flag_hit(mic_pkg::flags_s f, logic [2:0] tsel, logic sense);
    logic [7:0] v;
    v = f;
    return v[tsel] == sense;
  endfunction

  function automatic mic_pkg::addr_t branch_next(mic_pkg::addr_t a, logic take,
                                                 logic [7:0] off);
    if (take) return {a[mic_pkg::ADDR_W-1:8], off}; // Same page with new offset
    return a + 12'd1;
  endfunction

  task automatic check_addr(string name, mic_pkg::addr_t exp, mic_pkg::addr_t act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic report_timeout(string name, string what);
    timeouts++;
    $display("Timeout in %s, %s", name, what);
  endtask

  task automatic clear_store();
    for (int i = 0; i < 4096; i++) begin
      cstore[i] = jump_word(mic_pkg::OP_SEQ, mic_pkg::addr_t'(i)); // Field holds own address
    end
  endtask

  task automatic drive_inputs(mic_pkg::flags_s f, logic ld, mic_pkg::lc_t lv);
    @(posedge mclk);
    flags  <= f;
    ld_lc  <= ld;
    lc_val <= lv;
  endtask

  task automatic reset_dut(string name);
    @(posedge mclk);
    rst_n <= 1'b0;
    repeat (5) @(posedge mclk);
    rst_n <= 1'b1;
    @(negedge mclk);
    check_addr(name, '0, ma);
    check_bit(name, 1'b0, cond);
    check_bit(name, 1'b1, lcz);
    check_bit(name, 1'b0, deep);
  endtask

  task automatic next_cycle();
    @(posedge mclk);
    @(negedge mclk);
  endtask

  task automatic sequence_and_jump();
    string          name = "seq";
    mic_pkg::addr_t exp;
    clear_store();
    cstore[4]       = jump_word(mic_pkg::OP_JMP, 12'h3a0);
    cstore[12'h3a1] = jump_word(mic_pkg::OP_JMP, 12'h3a1); // Parks here
    reset_dut(name);
    exp = '0;
    for (int i = 0; i < 4; i++) begin
      next_cycle();
      exp = exp + 12'd1;
      check_addr(name, exp, ma);
    end
    next_cycle();
    check_addr(name, 12'h3a0, ma);
    next_cycle();
    check_addr(name, 12'h3a1, ma);
    next_cycle();
    check_addr(name, 12'h3a1, ma);
  endtask

  // Nested calls one page apart with each return word at offset 1
  task automatic call_and_return(string name, int n);
    mic_pkg::addr_t stk [$];
    mic_pkg::addr_t exp;
    clear_store();
    for (int k = 0; k < n; k++) begin
      cstore[k * 256]     = jump_word(mic_pkg::OP_CALL, mic_pkg::addr_t'((k + 1) * 256));
      cstore[k * 256 + 1] = jump_word(mic_pkg::OP_RET, '0);
    end
    cstore[n * 256] = jump_word(mic_pkg::OP_RET, '0);
    reset_dut(name);
    for (int k = 0; k < n; k++) begin
      stk.push_front(mic_pkg::addr_t'(k * 256 + 1));
      if (stk.size() > STACK_DEPTH) void'(stk.pop_back()); // Oldest return lost
      next_cycle();
      check_addr(name, mic_pkg::addr_t'((k + 1) * 256), ma);
      check_bit(name, stk.size() == STACK_DEPTH, deep);
    end
    for (int k = 0; k < n; k++) begin
      if (stk.size() != 0) begin
        exp = stk.pop_front();
      end else begin
        exp = '0;
      end
      next_cycle();
      check_addr(name, exp, ma);
      check_bit(name, stk.size() == STACK_DEPTH, deep);
    end
  endtask

  // Reset has to empty a full stack
  task automatic reset_when_full();
    string name = "reset_full";
    clear_store();
    for (int k = 0; k < STACK_DEPTH; k++) begin
      cstore[k] = jump_word(mic_pkg::OP_CALL, mic_pkg::addr_t'(k + 1));
    end
    reset_dut(name);
    for (int k = 0; k < STACK_DEPTH; k++) begin
      next_cycle();
    end
    check_bit(name, 1'b1, deep);
    reset_dut(name);
  endtask

  task automatic branch_each_flag();
    string      name = "cjmp";
    logic [7:0] fv;
    logic [7:0] off;
    logic       take;
    int         idx;
    idx = 0;
    for (int t = 0; t < 8; t++) begin
      for (int s = 0; s < 2; s++) begin
        for (int v = 0; v < 2; v++) begin
          fv = 8'h01 << t;
          if (v == 0) fv = ~fv; // Other flags always opposite
          take = (v == s);
          off  = 8'(idx * 5 + 3);
          clear_store();
          cstore[0]       = jump_word(mic_pkg::OP_JMP, 12'h7c0);
          cstore[12'h7c0] = cond_word(3'(t), 1'(s), off);
          drive_inputs(fv, 1'b0, '0);
          reset_dut(name);
          next_cycle();
          check_addr(name, 12'h7c0, ma);
          next_cycle();
          check_addr(name, take ? {4'h7, off} : 12'h7c1, ma);
          check_bit(name, take, cond);
          idx++;
        end
      end
    end
  endtask

  task automatic counted_loop();
    string name = "loop";
    int    extra;
    int    cycles;
    clear_store();
    cstore[0]       = jump_word(mic_pkg::OP_JMP, 12'h020);
    cstore[12'h020] = jump_word(mic_pkg::OP_LOOP, 12'h020);
    cstore[12'h021] = jump_word(mic_pkg::OP_JMP, 12'h021);
    drive_inputs('0, 1'b1, 6'd3);
    reset_dut(name);
    @(posedge mclk);
    ld_lc <= 1'b0; // Count loaded while at address 0
    @(negedge mclk);
    extra  = 0;
    cycles = 0;
    while (ma == 12'h020 && cycles < TIMEOUT) begin
      check_bit(name, extra == 3, lcz); // Zero only on the last pass
      next_cycle();
      if (ma == 12'h020) extra++;
      cycles++;
    end
    if (cycles >= TIMEOUT) report_timeout(name, "loop never fell through");
    check_addr(name, 12'h021, ma);
    check_bit(name, 1'b1, lcz);
    if (extra != 3) begin
      errors++;
      $display("Mismatch %s: expected 3 actual %0d extra passes", name, extra);
    end
  endtask

  // Each word is written at the address reached while flags change every cycle
  task automatic random_branches();
    string          name = "rand";
    logic [31:0]    rnd;
    mic_pkg::addr_t exp;
    logic           take;
    clear_store();
    reset_dut(name);
    exp  = '0;
    take = 1'b0;
    for (int k = 0; k < 41; k++) begin
      rnd = $random(seed);
      @(posedge mclk);
      flags <= rnd[7:0];
      @(negedge mclk);
      if (k != 0) begin
        check_addr(name, exp, ma);
        check_bit(name, take, cond);
      end
      rnd = $random(seed);
      cstore[ma] = cond_word(rnd[2:0], rnd[3], rnd[11:4]);
      take = flag_hit(flags, rnd[2:0], rnd[3]);
      exp  = branch_next(ma, take, rnd[11:4]);
    end
  endtask

  initial begin
    mclk     = 1'b0;
    rst_n    = 1'b0;
    flags    = '0;
    ld_lc    = 1'b0;
    lc_val   = '0;
    errors   = 0;
    timeouts = 0;
    seed     = 32'h65cf;
    clear_store();
    sequence_and_jump();
    call_and_return("call", STACK_DEPTH);
    call_and_return("call_over", STACK_DEPTH + 1);
    reset_when_full();
    branch_each_flag();
    counted_loop();
    random_branches();
    $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* sim/mic_props.sv */
/*
  Sequencer assertions
  Bound into mic_seq to watch the address register and the
  return stack pop path against the sequencing rules
*/
`timescale 1ns/1ps

module mic_props #(
  parameter int STACK_DEPTH = 4
) (
  input logic            mclk,
  input logic            rst_n,
  input mic_pkg::micro_s micro,
  input mic_pkg::addr_t  ma,
  input logic            push,
  input logic            pop
);

  int             occ;     // Shadow stack occupancy
  mic_pkg::addr_t ma_next;

  assign ma_next = ma + mic_pkg::addr_t'(1);

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      occ <= 0;
    end else if (push) begin
      if (occ < STACK_DEPTH) occ <= occ + 1;
    end else if (pop && occ != 0) begin
      occ <= occ - 1;
    end
  end

  a_reset_ma: assert property (@(posedge mclk) !rst_n |=> ma == '0)
    else $error("ma not zero after reset");

  a_seq_inc: assert property (@(posedge mclk)
    (rst_n && micro.op == mic_pkg::OP_SEQ) |=> ma == $past(ma_next))
    else $error("OP_SEQ did not advance ma by one");

  // Empty stack returns address 0
  a_pop_empty: assert property (@(posedge mclk)
    (rst_n && pop && occ == 0) |=> ma == '0)
    else $error("Pop on empty stack did not yield address 0");

endmodule

/* verilog/mic_top.sv */
/*
  Microprogram sequencer top level
  Condition and loop units decide side by side and the sequencer
  merges their take bits into the next control-store address
*/
`timescale 1ns/1ps

module mic_top #(
  parameter int STACK_DEPTH = 4
) (
  input  logic            mclk,
  input  logic            rst_n,
  input  mic_pkg::micro_s micro,
  input  mic_pkg::flags_s flags,
  input  logic            ld_lc,
  input  mic_pkg::lc_t    lc_val,
  output mic_pkg::addr_t  ma,
  output logic            cond,
  output logic            lcz,
  output logic            deep
);

  logic branch_take;
  logic loop_take;

  // Flag test and COND register
  mic_cond cond_i (
    .mclk        (mclk),
    .rst_n       (rst_n),
    .micro       (micro),
    .flags       (flags),
    .branch_take (branch_take),
    .cond        (cond)
  );

  // Loop counter
  mic_loop loop_i (
    .mclk      (mclk),
    .rst_n     (rst_n),
    .micro     (micro),
    .ld_lc     (ld_lc),
    .lc_val    (lc_val),
    .loop_take (loop_take),
    .lcz       (lcz)
  );

  mic_seq #(
    .STACK_DEPTH(STACK_DEPTH)
  ) seq_i (
    .mclk        (mclk),
    .rst_n       (rst_n),
    .micro       (micro),
    .branch_take (branch_take),
    .loop_take   (loop_take),
    .ma          (ma),
    .deep        (deep)
  );

endmodule

/* verilog/mic_seq.sv */
/*
  Next-address sequencer
  Builds ma+1, the absolute target and the paged branch target,
  then picks the next control-store address from the opcode and
  the take bits of the condition and loop units. Drives the
  return stack for calls and returns
*/
`timescale 1ns/1ps

module mic_seq #(
  parameter int STACK_DEPTH = 4
) (
  input  logic            mclk,
  input  logic            rst_n,
  input  mic_pkg::micro_s micro,
  input  logic            branch_take,
  input  logic            loop_take,
  output mic_pkg::addr_t  ma,
  output logic            deep
);

  mic_pkg::addr_t ma_inc;
  mic_pkg::addr_t jump_tgt;
  mic_pkg::addr_t page_tgt;
  mic_pkg::addr_t top_addr;
  mic_pkg::addr_t next_ma;
  logic           push;
  logic           pop;

  assign ma_inc   = ma + mic_pkg::addr_t'(1); // Incrementer
  assign jump_tgt = micro.field.jump.target;

  // Current page with offset replaced
  assign page_tgt = {ma[mic_pkg::ADDR_W-1:8], micro.field.cond.page_off};

  assign push = (micro.op == mic_pkg::OP_CALL);
  assign pop  = (micro.op == mic_pkg::OP_RET);

  always_comb begin
    case (micro.op)
      mic_pkg::OP_JMP:  next_ma = jump_tgt;
      mic_pkg::OP_CALL: next_ma = jump_tgt;
      mic_pkg::OP_RET:  next_ma = top_addr;
      mic_pkg::OP_CJMP: next_ma = branch_take ? page_tgt : ma_inc;
      mic_pkg::OP_LOOP: next_ma = loop_take ? jump_tgt : ma_inc;
      default:          next_ma = ma_inc; // OP_SEQ and spare codes
    endcase
  end

  // Microprogram address register
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      ma <= '0;
    end else begin
      ma <= next_ma;
    end
  end

  mic_stack #(
    .STACK_DEPTH(STACK_DEPTH)
  ) stack_i (
    .mclk     (mclk),
    .rst_n    (rst_n),
    .push     (push),
    .pop      (pop),
    .ret_addr (ma_inc), // Return lands after the call
    .top_addr (top_addr),
    .deep     (deep)
  );

endmodule

/* verilog/mic_stack.sv */
/*
  Return address stack
  Shift-register stack with an occupancy count. Newest entry sits
  in slot 0. A push on a full stack drops the oldest entry and a pop
  on an empty stack returns address 0
*/
`timescale 1ns/1ps

module mic_stack #(
  parameter int STACK_DEPTH = 4
) (
  input  logic           mclk,
  input  logic           rst_n,
  input  logic           push,
  input  logic           pop,
  input  mic_pkg::addr_t ret_addr,
  output mic_pkg::addr_t top_addr,
  output logic           deep
);

  localparam int CNT_W = $clog2(STACK_DEPTH + 1);

  mic_pkg::addr_t entry [STACK_DEPTH];
  logic [CNT_W-1:0] count_q;
  logic             empty;

  assign empty    = (count_q == '0);
  assign deep     = (count_q == CNT_W'(STACK_DEPTH));
  assign top_addr = empty ? '0 : entry[0];

  // Entry shifting
  always_ff @(posedge mclk) begin
    if (push) begin
      for (int i = STACK_DEPTH - 1; i > 0; i--) begin
        entry[i] <= entry[i-1];
      end
      entry[0] <= ret_addr;
    end else if (pop) begin
      for (int i = 0; i < STACK_DEPTH - 1; i++) begin
        entry[i] <= entry[i+1];
      end
    end
  end

  // Occupancy saturates at both ends
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (push) begin
      if (!deep) count_q <= count_q + CNT_W'(1);
    end else if (pop) begin
      if (!empty) count_q <= count_q - CNT_W'(1);
    end
  end

endmodule

/* verilog/mic_loop.sv */
/*
  Loop counter
  Loadable down counter for counted microcode loops.
  A loop word is taken while the count is non-zero and then
  decrements it; LCZ shows an exhausted count
*/
`timescale 1ns/1ps

module mic_loop (
  input  logic            mclk,
  input  logic            rst_n,
  input  mic_pkg::micro_s micro,
  input  logic            ld_lc,
  input  mic_pkg::lc_t    lc_val,
  output logic            loop_take,
  output logic            lcz
);

  mic_pkg::lc_t lc_q;

  assign lcz = (lc_q == '0);

  // Decision always uses the count held before this edge
  assign loop_take = (micro.op == mic_pkg::OP_LOOP) && !lcz;

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      lc_q <= '0;
    end else if (ld_lc) begin
      lc_q <= lc_val; // Load wins over count
    end else if (loop_take) begin
      lc_q <= lc_q - mic_pkg::lc_t'(1);
    end
  end

endmodule

/* verilog/mic_cond.sv */
/*
  Condition unit
  Selects one status flag by the microword tsel field, compares it
  with the sense bit and qualifies the result with OP_CJMP.
  The result of each conditional word is also kept on COND
*/
`timescale 1ns/1ps

module mic_cond (
  input  logic            mclk,
  input  logic            rst_n,
  input  mic_pkg::micro_s micro,
  input  mic_pkg::flags_s flags,
  output logic            branch_take,
  output logic            cond
);

  logic [7:0] flag_vec;
  logic       sel_flag;
  logic       test_ok;
  logic       is_cjmp;

  assign flag_vec = flags; // Flag index order follows the struct

  // Flag selection and sense compare
  assign sel_flag = flag_vec[micro.field.cond.tsel];
  assign test_ok  = (sel_flag == micro.field.cond.sense);
  assign is_cjmp  = (micro.op == mic_pkg::OP_CJMP);

  assign branch_take = is_cjmp & test_ok;

  // COND holds the last conditional test result
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      cond <= 1'b0;
    end else if (is_cjmp) begin
      cond <= test_ok;
    end
  end

endmodule

/* verilog/mic_pkg.sv */
/*
  Microprogram sequencer shared definitions
  Address and loop counter widths, sequencing opcodes, the microword
  layout with its two field views, and the status flag bundle
*/
package mic_pkg;

  localparam int ADDR_W = 12; // Control-store address width
  localparam int LC_W   = 6;  // Loop counter width

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LC_W-1:0]   lc_t;

  // Sequencing opcode of a microinstruction
  typedef enum logic [2:0] {
    OP_SEQ  = 3'd0, // ma+1
    OP_JMP  = 3'd1, // Absolute jump
    OP_CALL = 3'd2, // Push ma+1, jump
    OP_RET  = 3'd3, // Pop return address
    OP_CJMP = 3'd4, // Short branch within page
    OP_LOOP = 3'd5  // Counted loop to target
  } mic_op_e;

  // Status flags with zf at bit 0
  typedef struct packed {
    logic spare;
    logic stp;
    logic irq;
    logic f15;
    logic f11;
    logic ovf;
    logic cry;
    logic zf;
  } flags_s;

  // Jump view of the field bits
  typedef struct packed {
    addr_t target;
  } jump_view_s;

  // Condition view of the same bits
  typedef struct packed {
    logic [2:0] tsel;     // Flag index
    logic       sense;    // 1 tests for a set flag
    logic [7:0] page_off; // Offset within current page
  } cond_view_s;

  typedef union packed {
    jump_view_s jump;
    cond_view_s cond;
  } cs_field_u;

  // Full microword as seen by the sequencer
  typedef struct packed {
    mic_op_e   op;
    cs_field_u field;
  } micro_s;

endpackage
